/* verilog/line_pkg.sv */
// Scanline composer types
`default_nettype none

package line_pkg;

    // One pixel, also one host data byte
    typedef logic [7:0] pixel_t;

    // Tile word, two pixels with the low byte first
    typedef logic [15:0] word_t;

    // Tile memory byte address on the host side
    typedef logic [11:0] tile_addr_t;

    // Tile memory word address on the fetch side
    typedef logic [10:0] word_addr_t;

    // Sprite line memory byte address
    typedef logic [7:0] spr_addr_t;

    // Sprite value that lets the background show through
    localparam pixel_t transparent_pix = 8'h00;

    // Fetcher states, shared by both fetch paths
    typedef enum logic {
        fetch_idle,
        fetch_active
    } fetch_state_t;

endpackage

`default_nettype wire

/* verilog/dpram.sv */
// Equal width dual-port RAM
`default_nettype none
`timescale 1ns/1ns

module dpram #(
    parameter int addr_width = 8,
    parameter int data_width = 8
) (
    input  logic                  clka,
    // Port A
    input  logic [addr_width-1:0] address_a,
    input  logic [data_width-1:0] data_a,
    input  logic                  wren_a,
    output logic [data_width-1:0] q_a,
    // Port B
    input  logic [addr_width-1:0] address_b,
    input  logic [data_width-1:0] data_b,
    input  logic                  wren_b,
    output logic [data_width-1:0] q_b
);

    localparam int depth = 2 ** addr_width;

    logic [data_width-1:0] mem [depth];

    // Known contents from time zero
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // Port A, read returns the old word on a write
    always @(posedge clka) begin
        if (wren_a) begin
            mem[address_a] <= data_a;
        end
        q_a <= mem[address_a];
    end

    // Port B, same read-before-write order
    always @(posedge clka) begin
        if (wren_b) begin
            mem[address_b] <= data_b;
        end
        q_b <= mem[address_b];
    end

    // Both ports writing one word in one cycle has no defined winner
    a_no_write_clash: assert property (
        @(posedge clka) !(wren_a && wren_b && (address_a == address_b))
    ) else $error("dpram: both ports write address %0h", address_a);

endmodule

`default_nettype wire

/* verilog/dpram_dif.sv */
// Mixed width dual-port RAM
`default_nettype none
`timescale 1ns/1ns

module dpram_dif #(
    parameter int addr_width_a = 12,
    parameter int data_width_a = 8,
    parameter int addr_width_b = 11,
    parameter int data_width_b = 16
) (
    input  logic                    clka,
    // Port A, narrow side
    input  logic [addr_width_a-1:0] address_a,
    input  logic [data_width_a-1:0] data_a,
    input  logic                    wren_a,
    output logic [data_width_a-1:0] q_a,
    // Port B, wide side
    input  logic [addr_width_b-1:0] address_b,
    input  logic [data_width_b-1:0] data_b,
    input  logic                    wren_b,
    output logic [data_width_b-1:0] q_b
);

    // Byte array covers whichever port sees more bytes
    localparam int depth_a = 2 ** addr_width_a;
    localparam int depth_b = 2 ** (addr_width_b + 1);
    localparam int mem_size = (depth_a > depth_b) ? depth_a : depth_b;

    logic [data_width_a-1:0] mem [mem_size];

    // Even and odd byte of the word on port B
    logic [addr_width_b:0] lo_addr;
    logic [addr_width_b:0] hi_addr;

    assign lo_addr = {address_b, 1'b0};
    assign hi_addr = {address_b, 1'b1};

    initial begin
        for (int i = 0; i < mem_size; i++) begin
            mem[i] = '0;
        end
    end

    // Port B packs exactly two port A bytes
    initial begin
        a_width_ratio: assert (data_width_b == 2 * data_width_a)
            else $error("dpram_dif: port B must be twice port A width");
    end

    // Port A, byte access
    always @(posedge clka) begin
        if (wren_a) begin
            mem[address_a] <= data_a;
        end
        q_a <= mem[address_a];
    end

    // Port B, little-endian word access
    always @(posedge clka) begin
        if (wren_b) begin
            mem[lo_addr] <= data_b[data_width_a-1:0];
            mem[hi_addr] <= data_b[data_width_b-1:data_width_a];
        end
        q_b <= {mem[hi_addr], mem[lo_addr]};
    end

endmodule

`default_nettype wire

/* verilog/bg_fetch.sv */
// Background tile fetcher
`default_nettype none
`timescale 1ns/1ns

module bg_fetch #(
    parameter int line_pixels = 64
) (
    input  bit                   clka,
    input  bit                   rst,
    input  bit                   line_start,
    input  line_pkg::word_addr_t bg_base,
    output line_pkg::word_addr_t word_addr,
    input  line_pkg::word_t      word_data,
    output line_pkg::pixel_t     bg_pix,
    output bit                   bg_valid,
    output bit                   bg_last
);

    localparam int cnt_w = $clog2(line_pixels);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(line_pixels - 1);

    line_pkg::fetch_state_t state;
    logic [cnt_w-1:0]       pix_cnt;
    line_pkg::word_addr_t   next_addr;

    // Issue stage, lines up with the registered address
    logic iss_valid;
    logic iss_last;
    logic iss_high;
    // Data stage, lines up with the RAM output
    logic dat_high;

    // Walk the line, one pixel per cycle
    always_ff @(posedge clka) begin
        if (rst) begin
            state   <= line_pkg::fetch_idle;
            pix_cnt <= '0;
        end else if (state == line_pkg::fetch_idle) begin
            // Start pulse is only seen while idle
            if (line_start) begin
                state   <= line_pkg::fetch_active;
                pix_cnt <= '0;
            end
        end else begin
            pix_cnt <= pix_cnt + 1'b1;
            if (pix_cnt == last_cnt) begin
                state <= line_pkg::fetch_idle;
            end
        end
    end

    // New word on even pixels, held across the odd one
    always_ff @(posedge clka) begin
        if (state == line_pkg::fetch_idle && line_start) begin
            next_addr <= bg_base;
        end else if (state == line_pkg::fetch_active && !pix_cnt[0]) begin
            word_addr <= next_addr;
            next_addr <= next_addr + 1'b1;
        end
        iss_high <= pix_cnt[0];
        dat_high <= iss_high;
    end

    // Valid and last follow the address through the RAM latency
    always_ff @(posedge clka) begin
        if (rst) begin
            iss_valid <= 1'b0;
            iss_last  <= 1'b0;
            bg_valid  <= 1'b0;
            bg_last   <= 1'b0;
        end else begin
            iss_valid <= (state == line_pkg::fetch_active);
            iss_last  <= (state == line_pkg::fetch_active) && (pix_cnt == last_cnt);
            bg_valid  <= iss_valid;
            bg_last   <= iss_last;
        end
    end

    // Low byte is the even pixel
    assign bg_pix = dat_high ? word_data[15:8] : word_data[7:0];

    a_last_in_line: assert property (
        @(posedge clka) disable iff (rst) bg_last |-> bg_valid
    ) else $error("bg_fetch: last pixel outside a valid line");

endmodule

`default_nettype wire

/* verilog/spr_fetch.sv */
// Sprite line fetcher
`default_nettype none
`timescale 1ns/1ns

module spr_fetch #(
    parameter int line_pixels = 64
) (
    input  bit                  clka,
    input  bit                  rst,
    input  bit                  line_start,
    input  line_pkg::spr_addr_t spr_base,
    output line_pkg::spr_addr_t spr_rd_addr,
    input  line_pkg::pixel_t    spr_rd_data,
    output line_pkg::pixel_t    spr_pix
);

    localparam int cnt_w = $clog2(line_pixels);
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(line_pixels - 1);

    line_pkg::fetch_state_t state;
    logic [cnt_w-1:0]       pix_cnt;
    line_pkg::spr_addr_t    next_addr;
    // Line marker, one stage per cycle of RAM latency
    logic iss_valid;
    logic dat_valid;

    always_ff @(posedge clka) begin
        if (rst) begin
            state     <= line_pkg::fetch_idle;
            pix_cnt   <= '0;
            iss_valid <= 1'b0;
            dat_valid <= 1'b0;
        end else begin
            if (state == line_pkg::fetch_idle) begin
                if (line_start) begin
                    state   <= line_pkg::fetch_active;
                    pix_cnt <= '0;
                end
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
                if (pix_cnt == last_cnt) begin
                    state <= line_pkg::fetch_idle;
                end
            end
            iss_valid <= (state == line_pkg::fetch_active);
            dat_valid <= iss_valid;
        end
    end

    // Byte address steps every pixel, wraps at the top
    always_ff @(posedge clka) begin
        if (state == line_pkg::fetch_idle && line_start) begin
            next_addr <= spr_base;
        end else if (state == line_pkg::fetch_active) begin
            spr_rd_addr <= next_addr;
            next_addr   <= next_addr + 1'b1;
        end
    end

    // Transparent between lines
    assign spr_pix = dat_valid ? spr_rd_data : line_pkg::transparent_pix;

endmodule

`default_nettype wire

/* verilog/pixel_mix.sv */
// Sprite over background mixer
`default_nettype none
`timescale 1ns/1ns

module pixel_mix (
    input  bit               clka,
    input  bit               rst,
    input  line_pkg::pixel_t bg_pix,
    input  bit               bg_valid,
    input  bit               bg_last,
    input  line_pkg::pixel_t spr_pix,
    output line_pkg::pixel_t pixel_out,
    output bit               pixel_valid,
    output bit               line_done
);

    line_pkg::pixel_t mix_pix;

    // Opaque sprite pixel has priority
    always_comb begin
        if (spr_pix != line_pkg::transparent_pix) begin
            mix_pix = spr_pix;
        end else begin
            mix_pix = bg_pix;
        end
    end

    always_ff @(posedge clka) begin
        pixel_out <= mix_pix;
    end

    // Valid and last ride with the pixel
    always_ff @(posedge clka) begin
        if (rst) begin
            pixel_valid <= 1'b0;
            line_done   <= 1'b0;
        end else begin
            pixel_valid <= bg_valid;
            line_done   <= bg_last;
        end
    end

    a_done_valid: assert property (
        @(posedge clka) disable iff (rst) line_done |-> pixel_valid
    ) else $error("pixel_mix: line_done without pixel_valid");

endmodule

`default_nettype wire

/* verilog/line_composer.sv */
// Scanline composer top
`default_nettype none
`timescale 1ns/1ns

module line_composer #(
    parameter int line_pixels = 64
) (
    input  bit                   clka,
    input  bit                   rst,
    // Host side of the tile memory
    input  line_pkg::tile_addr_t tile_addr,
    input  line_pkg::pixel_t     tile_wdata,
    input  bit                   tile_we,
    output line_pkg::pixel_t     tile_rdata,
    // Host side of the sprite memory
    input  line_pkg::spr_addr_t  spr_addr,
    input  line_pkg::pixel_t     spr_wdata,
    input  bit                   spr_we,
    // Line control
    input  bit                   line_start,
    input  line_pkg::word_addr_t bg_base,
    input  line_pkg::spr_addr_t  spr_base,
    // Pixel stream
    output line_pkg::pixel_t     pixel_out,
    output bit                   pixel_valid,
    output bit                   line_done
);

    line_pkg::word_addr_t word_addr;
    line_pkg::word_t      word_data;
    line_pkg::spr_addr_t  spr_rd_addr;
    line_pkg::pixel_t     spr_rd_data;
    line_pkg::pixel_t     bg_pix;
    bit                   bg_valid;
    bit                   bg_last;
    line_pkg::pixel_t     spr_pix;

    // Tile memory, bytes in from the host, words out to the fetcher
    dpram_dif #(
        .addr_width_a ($bits(line_pkg::tile_addr_t)),
        .data_width_a ($bits(line_pkg::pixel_t)),
        .addr_width_b ($bits(line_pkg::word_addr_t)),
        .data_width_b ($bits(line_pkg::word_t))
    ) tile_ram (
        .clka      (clka),
        .address_a (tile_addr),
        .data_a    (tile_wdata),
        .wren_a    (tile_we),
        .q_a       (tile_rdata),
        .address_b (word_addr),
        .data_b    ('0),
        .wren_b    (1'b0),
        .q_b       (word_data)
    );

    // Sprite line memory, read only on port B
    dpram #(
        .addr_width ($bits(line_pkg::spr_addr_t)),
        .data_width ($bits(line_pkg::pixel_t))
    ) spr_ram (
        .clka      (clka),
        .address_a (spr_addr),
        .data_a    (spr_wdata),
        .wren_a    (spr_we),
        .q_a       (),
        .address_b (spr_rd_addr),
        .data_b    ('0),
        .wren_b    (1'b0),
        .q_b       (spr_rd_data)
    );

    bg_fetch #(.line_pixels(line_pixels)) u_bg_fetch (
        .clka       (clka),
        .rst        (rst),
        .line_start (line_start),
        .bg_base    (bg_base),
        .word_addr  (word_addr),
        .word_data  (word_data),
        .bg_pix     (bg_pix),
        .bg_valid   (bg_valid),
        .bg_last    (bg_last)
    );

    spr_fetch #(.line_pixels(line_pixels)) u_spr_fetch (
        .clka        (clka),
        .rst         (rst),
        .line_start  (line_start),
        .spr_base    (spr_base),
        .spr_rd_addr (spr_rd_addr),
        .spr_rd_data (spr_rd_data),
        .spr_pix     (spr_pix)
    );

    pixel_mix u_pixel_mix (
        .clka        (clka),
        .rst         (rst),
        .bg_pix      (bg_pix),
        .bg_valid    (bg_valid),
        .bg_last     (bg_last),
        .spr_pix     (spr_pix),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid),
        .line_done   (line_done)
    );

endmodule

`default_nettype wire

/* verif/line_composer_tb.sv */
// Scanline composer testbench
`default_nettype none
`timescale 1ns/1ns

module line_composer_tb;

    localparam int line_pixels = 64;
    localparam int tile_checks = 32;
    localparam int line_count  = 5;
    // Cycles spent on reset, idle watch, host port traffic and memory fills
    localparam int fill_cycles = 40 + 3 * tile_checks + line_count * 3 * line_pixels;
    localparam int watchdog_ns = 2 * (fill_cycles + line_count * (line_pixels + 10)) * 4;

    logic                 clka;
    logic                 rst;
    line_pkg::tile_addr_t tile_addr;
    line_pkg::pixel_t     tile_wdata;
    logic                 tile_we;
    line_pkg::pixel_t     tile_rdata;
    line_pkg::spr_addr_t  spr_addr;
    line_pkg::pixel_t     spr_wdata;
    logic                 spr_we;
    logic                 line_start;
    line_pkg::word_addr_t bg_base;
    line_pkg::spr_addr_t  spr_base;
    line_pkg::pixel_t     pixel_out;
    logic                 pixel_valid;
    logic                 line_done;

    // Host view of both memories
    line_pkg::pixel_t tile_shadow [4096];
    line_pkg::pixel_t spr_shadow [256];

    line_composer #(.line_pixels(line_pixels)) DUT (
        .clka        (clka),
        .rst         (rst),
        .tile_addr   (tile_addr),
        .tile_wdata  (tile_wdata),
        .tile_we     (tile_we),
        .tile_rdata  (tile_rdata),
        .spr_addr    (spr_addr),
        .spr_wdata   (spr_wdata),
        .spr_we      (spr_we),
        .line_start  (line_start),
        .bg_base     (bg_base),
        .spr_base    (spr_base),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid),
        .line_done   (line_done)
    );

    // 4 ns clock
    initial begin
        clka = 1'b0;
        forever #2 clka = ~clka;
    end

    // Hard limit on the whole run
    initial begin
        #(watchdog_ns);
        $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("error @ %0t ns: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
            $display("Test failures found");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Sprite wins unless transparent
    // Tile byte index is twice the word base plus k
    function automatic line_pkg::pixel_t expected_pixel(input line_pkg::word_addr_t b,
                                                        input line_pkg::spr_addr_t s,
                                                        input int k);
        line_pkg::pixel_t bg_byte;
        line_pkg::pixel_t spr_byte;
        bg_byte  = tile_shadow[(2 * int'(b) + k) % 4096];
        spr_byte = spr_shadow[(int'(s) + k) % 256];
        if (spr_byte != 8'h00) begin
            return spr_byte;
        end
        return bg_byte;
    endfunction

    // Random bytes for the tile bytes of one line that wrap at 4096
    task automatic fill_tile(input line_pkg::word_addr_t b, input int n);
        line_pkg::tile_addr_t a;
        line_pkg::pixel_t     d;
        for (int i = 0; i < n; i++) begin
            a = line_pkg::tile_addr_t'(2 * int'(b) + i);
            d = line_pkg::pixel_t'($urandom);
            @(posedge clka);
            tile_addr  <= a;
            tile_wdata <= d;
            tile_we    <= 1'b1;
            tile_shadow[a] = d;
        end
        @(posedge clka);
        tile_we <= 1'b0;
    endtask

    // Sprite bytes with roughly half of them transparent
    task automatic fill_sprite(input line_pkg::spr_addr_t s, input int n);
        line_pkg::spr_addr_t a;
        line_pkg::pixel_t    d;
        for (int i = 0; i < n; i++) begin
            a = line_pkg::spr_addr_t'(int'(s) + i);
            d = ($urandom % 2 == 0) ? 8'h00 : line_pkg::pixel_t'($urandom);
            @(posedge clka);
            spr_addr  <= a;
            spr_wdata <= d;
            spr_we    <= 1'b1;
            spr_shadow[a] = d;
        end
        @(posedge clka);
        spr_we <= 1'b0;
    endtask

    // Start a line and check every output cycle
    // With restart set, line_start pulses again mid-line
    task automatic run_line(input line_pkg::word_addr_t b, input line_pkg::spr_addr_t s,
                            input bit restart);
        int cycles;
        line_pkg::pixel_t exp_pix;
        @(posedge clka);
        line_start <= 1'b1;
        bg_base    <= b;
        spr_base   <= s;
        // Any earlier line has ended by this cycle
        @(negedge clka);
        check_value(pixel_valid, 1'b0, "pixel_valid before the line starts");
        check_value(line_done, 1'b0, "line_done before the line starts");
        @(posedge clka);
        line_start <= 1'b0;
        cycles = 0;
        @(negedge clka);
        while (!pixel_valid && cycles < line_pixels + 10) begin
            @(negedge clka);
            cycles++;
        end
        if (!pixel_valid) begin
            $display("pixel_valid never rose after line_start at %0t ns", $time);
            $display("Test failures found");
            $fatal(1, "line did not start");
        end
        check_value(cycles, 3, "cycles from line_start to first pixel_valid");
        for (int k = 0; k < line_pixels; k++) begin
            exp_pix = expected_pixel(b, s, k);
            check_value(pixel_valid, 1'b1, $sformatf("pixel_valid at pixel %0d", k));
            check_value(pixel_out, exp_pix, $sformatf("pixel_out at pixel %0d", k));
            check_value(line_done, (k == line_pixels - 1),
                        $sformatf("line_done at pixel %0d", k));
            if (k < line_pixels - 1) begin
                @(posedge clka);
                // Ignored while both fetchers are active
                if (restart && k == line_pixels / 2) begin
                    line_start <= 1'b1;
                    bg_base    <= b + 11'd5;
                    spr_base   <= s + 8'd7;
                end else begin
                    line_start <= 1'b0;
                end
                @(negedge clka);
            end
        end
    endtask

    task automatic test_reset();
        repeat (20) begin
            @(negedge clka);
            check_value(pixel_valid, 1'b0, "pixel_valid while idle");
            check_value(line_done, 1'b0, "line_done while idle");
        end
    endtask

    task automatic test_tile_port();
        line_pkg::tile_addr_t addrs [tile_checks];
        line_pkg::pixel_t     d;
        for (int i = 0; i < tile_checks; i++) begin
            addrs[i] = line_pkg::tile_addr_t'($urandom);
            d = line_pkg::pixel_t'($urandom);
            @(posedge clka);
            tile_addr  <= addrs[i];
            tile_wdata <= d;
            tile_we    <= 1'b1;
            tile_shadow[addrs[i]] = d;
        end
        @(posedge clka);
        tile_we <= 1'b0;
        // Read data one cycle after the address
        for (int i = 0; i < tile_checks; i++) begin
            @(posedge clka);
            tile_addr <= addrs[i];
            @(posedge clka);
            @(negedge clka);
            check_value(tile_rdata, tile_shadow[addrs[i]],
                        $sformatf("tile_rdata at %0h", addrs[i]));
        end
    endtask

    // Sprite memory still all zero here
    task automatic test_bg_line();
        line_pkg::word_addr_t b;
        line_pkg::spr_addr_t  s;
        b = line_pkg::word_addr_t'($urandom % (2048 - line_pixels));
        s = line_pkg::spr_addr_t'($urandom % (256 - line_pixels));
        fill_tile(b, line_pixels);
        run_line(b, s, 1'b0);
    endtask

    task automatic test_sprite_overlay();
        line_pkg::word_addr_t b;
        line_pkg::spr_addr_t  s;
        b = line_pkg::word_addr_t'($urandom % (2048 - line_pixels));
        s = line_pkg::spr_addr_t'($urandom % (256 - line_pixels));
        fill_tile(b, line_pixels);
        fill_sprite(s, line_pixels);
        run_line(b, s, 1'b0);
    endtask

    // Second line starts the cycle after line_done
    task automatic test_restart_back_to_back();
        line_pkg::word_addr_t b1;
        line_pkg::word_addr_t b2;
        line_pkg::spr_addr_t  s1;
        line_pkg::spr_addr_t  s2;
        b1 = line_pkg::word_addr_t'($urandom);
        b2 = line_pkg::word_addr_t'($urandom);
        s1 = line_pkg::spr_addr_t'($urandom);
        s2 = line_pkg::spr_addr_t'($urandom);
        fill_tile(b1, line_pixels);
        fill_sprite(s1, line_pixels);
        fill_tile(b2, line_pixels);
        fill_sprite(s2, line_pixels);
        run_line(b1, s1, 1'b1);
        run_line(b2, s2, 1'b0);
    endtask

    // Both bases close to the top so the line crosses address zero
    task automatic test_wrap();
        line_pkg::word_addr_t b;
        line_pkg::spr_addr_t  s;
        b = line_pkg::word_addr_t'(2048 - line_pixels / 4);
        s = line_pkg::spr_addr_t'(256 - line_pixels / 2);
        fill_tile(b, line_pixels);
        fill_sprite(s, line_pixels);
        run_line(b, s, 1'b0);
    endtask

    initial begin
        void'($urandom(46027));
        rst        = 1'b1;
        tile_addr  = '0;
        tile_wdata = '0;
        tile_we    = 1'b0;
        spr_addr   = '0;
        spr_wdata  = '0;
        spr_we     = 1'b0;
        line_start = 1'b0;
        bg_base    = '0;
        spr_base   = '0;
        // Memories start cleared
        for (int i = 0; i < 4096; i++) begin
            tile_shadow[i] = 8'h00;
        end
        for (int i = 0; i < 256; i++) begin
            spr_shadow[i] = 8'h00;
        end
        repeat (10) @(posedge clka);
        rst <= 1'b0;
        test_reset();
        test_tile_port();
        test_bg_line();
        test_sprite_overlay();
        test_restart_back_to_back();
        test_wrap();
        // Stream stops right after the last pixel
        @(negedge clka);
        check_value(pixel_valid, 1'b0, "pixel_valid after the last line");
        check_value(line_done, 1'b0, "line_done after the last line");
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
verilog/line_pkg.sv
verilog/dpram.sv
verilog/dpram_dif.sv
verilog/bg_fetch.sv
verilog/spr_fetch.sv
verilog/pixel_mix.sv
verilog/line_composer.sv
verif/line_composer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scanline composer testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module line_composer_tb -o line_composer_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/line_composer_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failures found" "$log"; then
    exit 1
fi
exit 0
